// File: design/cache_pkg.sv
package cache_pkg;

   // Geometry defaults, the top level passes these down
   parameter int DATA_W_DEF      = 32;  // Data word width
   parameter int ADDR_W_DEF      = 12;  // Word address width
   parameter int INDEX_W_DEF     = 4;   // 16 lines
   parameter int WTB_DEPTH_W_DEF = 2;   // 4 write buffer entries

   // Cache controller states
   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,  // Waiting for an access
      ST_DRAIN   = 2'd1,  // Read miss, write buffer emptying
      ST_FETCH   = 2'd2,  // Read miss, line read from memory
      ST_RESPOND = 2'd3   // Filled word returned
   } cache_state_e;

endpackage

// File: design/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

   // Control port register map
   typedef enum logic [3:0] {
      CTRL_RW_HIT     = 4'd0,   // Read plus write hits
      CTRL_RW_MISS    = 4'd1,   // Read plus write misses
      CTRL_READ_HIT   = 4'd2,
      CTRL_READ_MISS  = 4'd3,
      CTRL_WRITE_HIT  = 4'd4,
      CTRL_WRITE_MISS = 4'd5,
      CTRL_RST_CNTRS  = 4'd6,   // Command, clears counters
      CTRL_INVALIDATE = 4'd7,   // Command, clears valid bits
      CTRL_WTB_EMPTY  = 4'd8,
      CTRL_WTB_FULL   = 4'd9,
      CTRL_VERSION    = 4'd10
   } ctrl_reg_e;

   parameter logic [31:0] CACHE_VERSION = 32'h0001_0200;  // Major 1, minor 2

endpackage

// File: design/cache_memory.sv
`timescale 1ns/100ps

module cache_memory #(
   parameter int DATA_W  = cache_pkg::DATA_W_DEF,
   parameter int ADDR_W  = cache_pkg::ADDR_W_DEF,
   parameter int INDEX_W = cache_pkg::INDEX_W_DEF
) (
   input  logic              clk,
   input  logic              reset,
   // Processor side
   input  logic              valid,
   input  logic              write,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata,
   output logic              ready,
   input  logic              invalidate,
   // Miss fetch through the back end
   output logic              fetch_req,
   output logic [ADDR_W-1:0] fetch_addr,
   input  logic [DATA_W-1:0] fetch_data,
   input  logic              fetch_done,
   // Write-through buffer
   output logic              wtb_push,
   output logic [ADDR_W-1:0] wtb_addr,
   output logic [DATA_W-1:0] wtb_data,
   input  logic              wtbuf_full,
   input  logic              wtbuf_empty,
   // Event pulses to the control block
   output logic              read_hit,
   output logic              read_miss,
   output logic              write_hit,
   output logic              write_miss
);

   import cache_pkg::*;

   localparam int TAG_W = ADDR_W - INDEX_W;
   localparam int LINES = 1 << INDEX_W;

   cache_state_e state;

   logic [TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]  data_mem [LINES];
   logic [LINES-1:0]   valid_bits;

   logic [INDEX_W-1:0] index;
   logic [TAG_W-1:0]   tag;
   logic               hit;
   logic               accept;
   logic               rd_hit_acc;
   logic               wr_acc;
   logic               fill;

   assign index = addr[INDEX_W-1:0];
   assign tag   = addr[ADDR_W-1:INDEX_W];
   assign hit   = valid_bits[index] && (tag_mem[index] == tag);

   // A request is still held high in its ready cycle, so skip that one
   assign accept     = (state == ST_IDLE) && valid && !ready;
   assign rd_hit_acc = accept && !write && hit;
   assign wr_acc     = accept && write && !wtbuf_full;  // Waits while buffer full
   assign fill       = (state == ST_FETCH) && fetch_done;

   assign wtb_push   = wr_acc;
   assign wtb_addr   = addr;
   assign wtb_data   = wdata;

   assign fetch_req  = (state == ST_FETCH);
   assign fetch_addr = addr;  // Held by the processor until ready

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state      <= ST_IDLE;
         ready      <= 1'b0;
         valid_bits <= '0;
         read_hit   <= 1'b0;
         read_miss  <= 1'b0;
         write_hit  <= 1'b0;
         write_miss <= 1'b0;
      end else begin
         ready      <= 1'b0;
         read_hit   <= 1'b0;
         read_miss  <= 1'b0;
         write_hit  <= 1'b0;
         write_miss <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (wr_acc) begin
                  ready      <= 1'b1;
                  write_hit  <= hit;
                  write_miss <= !hit;
               end else if (rd_hit_acc) begin
                  ready    <= 1'b1;
                  read_hit <= 1'b1;
               end else if (accept && !write) begin
                  read_miss <= 1'b1;  // Decided now, served later
                  state     <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (wtbuf_empty) state <= ST_FETCH;  // Older writes reach memory first
            end
            ST_FETCH: begin
               if (fetch_done) begin
                  valid_bits[index] <= 1'b1;
                  ready             <= 1'b1;
                  state             <= ST_RESPOND;
               end
            end
            ST_RESPOND: begin
               state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
         if (invalidate) valid_bits <= '0;
      end
   end

   // Arrays and read data
   always_ff @(posedge clk) begin
      if (rd_hit_acc) rdata <= data_mem[index];
      if (wr_acc && hit) data_mem[index] <= wdata;  // No allocate on write miss
      if (fill) begin
         data_mem[index] <= fetch_data;
         tag_mem[index]  <= tag;
         rdata           <= fetch_data;
      end
   end

endmodule

// File: design/write_through_backend.sv
`timescale 1ns/100ps

module write_through_backend #(
   parameter int DATA_W      = cache_pkg::DATA_W_DEF,
   parameter int ADDR_W      = cache_pkg::ADDR_W_DEF,
   parameter int WTB_DEPTH_W = cache_pkg::WTB_DEPTH_W_DEF
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              wtb_push,
   input  logic [ADDR_W-1:0] wtb_addr,
   input  logic [DATA_W-1:0] wtb_data,
   output logic              wtbuf_full,
   output logic              wtbuf_empty,
   input  logic              fetch_req,
   input  logic [ADDR_W-1:0] fetch_addr,
   output logic [DATA_W-1:0] fetch_data,
   output logic              fetch_done,
   output logic              mem_valid,
   output logic              mem_write,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [DATA_W-1:0] mem_wdata,
   input  logic [DATA_W-1:0] mem_rdata,
   input  logic              mem_ready
);

   localparam int DEPTH = 1 << WTB_DEPTH_W;

   logic [ADDR_W-1:0]      addr_q [DEPTH];
   logic [DATA_W-1:0]      data_q [DEPTH];
   logic [WTB_DEPTH_W-1:0] wr_ptr;
   logic [WTB_DEPTH_W-1:0] rd_ptr;
   logic [WTB_DEPTH_W:0]   count;  // Includes the entry in flight
   logic                   push;
   logic                   pop;

   assign wtbuf_full  = (count == (WTB_DEPTH_W+1)'(DEPTH));
   assign wtbuf_empty = (count == '0);
   assign push        = wtb_push && !wtbuf_full;
   assign pop         = mem_valid && mem_ready && mem_write;  // Head leaves once accepted
   assign fetch_done  = mem_valid && mem_ready && !mem_write;
   assign fetch_data  = mem_rdata;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         mem_valid <= 1'b0;
         mem_write <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (mem_valid) begin
            if (mem_ready) mem_valid <= 1'b0;
         end else if (!wtbuf_empty) begin
            mem_valid <= 1'b1;
            mem_write <= 1'b1;
         end else if (fetch_req) begin  // Reads only behind an empty buffer
            mem_valid <= 1'b1;
            mem_write <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         addr_q[wr_ptr] <= wtb_addr;
         data_q[wr_ptr] <= wtb_data;
      end
      if (!mem_valid) begin
         if (!wtbuf_empty) begin
            mem_addr  <= addr_q[rd_ptr];
            mem_wdata <= data_q[rd_ptr];
         end else begin
            mem_addr <= fetch_addr;
         end
      end
   end

endmodule

// File: design/cache_control.sv
`timescale 1ns/100ps

module cache_control #(
   parameter int DATA_W       = cache_pkg::DATA_W_DEF,
   parameter int USE_CTRL_CNT = 1
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      ctrl_valid,
   input  cache_ctrl_pkg::ctrl_reg_e ctrl_addr,
   output logic [DATA_W-1:0]         ctrl_rdata,
   output logic                      ctrl_ready,
   input  logic                      wtbuf_full,
   input  logic                      wtbuf_empty,
   input  logic                      read_hit,
   input  logic                      read_miss,
   input  logic                      write_hit,
   input  logic                      write_miss,
   output logic                      invalidate
);

   import cache_ctrl_pkg::*;

   logic [DATA_W-1:0] read_hit_cnt;
   logic [DATA_W-1:0] read_miss_cnt;
   logic [DATA_W-1:0] write_hit_cnt;
   logic [DATA_W-1:0] write_miss_cnt;
   logic              clear_cntrs;
   logic              accept;

   assign accept = ctrl_valid && !ctrl_ready;  // One ack per request

   generate
      if (USE_CTRL_CNT != 0) begin : g_cnt
         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               read_hit_cnt   <= '0;
               read_miss_cnt  <= '0;
               write_hit_cnt  <= '0;
               write_miss_cnt <= '0;
            end else if (clear_cntrs) begin
               read_hit_cnt   <= '0;
               read_miss_cnt  <= '0;
               write_hit_cnt  <= '0;
               write_miss_cnt <= '0;
            end else begin
               if (read_hit) read_hit_cnt <= read_hit_cnt + 1'b1;
               if (read_miss) read_miss_cnt <= read_miss_cnt + 1'b1;
               if (write_hit) write_hit_cnt <= write_hit_cnt + 1'b1;
               if (write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
            end
         end
      end else begin : g_no_cnt
         assign read_hit_cnt   = '0;  // Counter addresses read zero
         assign read_miss_cnt  = '0;
         assign write_hit_cnt  = '0;
         assign write_miss_cnt = '0;
      end
   endgenerate

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_ready  <= 1'b0;
         invalidate  <= 1'b0;
         clear_cntrs <= 1'b0;
      end else begin
         ctrl_ready  <= accept;
         invalidate  <= accept && (ctrl_addr == CTRL_INVALIDATE);
         clear_cntrs <= accept && (ctrl_addr == CTRL_RST_CNTRS);
      end
   end

   always_ff @(posedge clk) begin
      ctrl_rdata <= '0;
      if (accept) begin
         case (ctrl_addr)
            CTRL_RW_HIT:     ctrl_rdata <= read_hit_cnt + write_hit_cnt;
            CTRL_RW_MISS:    ctrl_rdata <= read_miss_cnt + write_miss_cnt;
            CTRL_READ_HIT:   ctrl_rdata <= read_hit_cnt;
            CTRL_READ_MISS:  ctrl_rdata <= read_miss_cnt;
            CTRL_WRITE_HIT:  ctrl_rdata <= write_hit_cnt;
            CTRL_WRITE_MISS: ctrl_rdata <= write_miss_cnt;
            CTRL_WTB_EMPTY:  ctrl_rdata <= DATA_W'(wtbuf_empty);
            CTRL_WTB_FULL:   ctrl_rdata <= DATA_W'(wtbuf_full);
            CTRL_VERSION:    ctrl_rdata <= DATA_W'(CACHE_VERSION);
            default:         ctrl_rdata <= '0;  // Commands and unknown addresses
         endcase
      end
   end

endmodule

// File: design/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
   parameter int DATA_W       = cache_pkg::DATA_W_DEF,
   parameter int ADDR_W       = cache_pkg::ADDR_W_DEF,
   parameter int INDEX_W      = cache_pkg::INDEX_W_DEF,
   parameter int WTB_DEPTH_W  = cache_pkg::WTB_DEPTH_W_DEF,
   parameter int USE_CTRL_CNT = 1
) (
   input  logic                      clk,
   input  logic                      reset,
   // Processor port
   input  logic                      valid,
   input  logic                      write,
   input  logic [ADDR_W-1:0]         addr,
   input  logic [DATA_W-1:0]         wdata,
   output logic [DATA_W-1:0]         rdata,
   output logic                      ready,
   // Control port
   input  logic                      ctrl_valid,
   input  cache_ctrl_pkg::ctrl_reg_e ctrl_addr,
   output logic [DATA_W-1:0]         ctrl_rdata,
   output logic                      ctrl_ready,
   // Memory port
   output logic                      mem_valid,
   output logic                      mem_write,
   output logic [ADDR_W-1:0]         mem_addr,
   output logic [DATA_W-1:0]         mem_wdata,
   input  logic [DATA_W-1:0]         mem_rdata,
   input  logic                      mem_ready
);

   logic              invalidate;
   logic              fetch_req;
   logic [ADDR_W-1:0] fetch_addr;
   logic [DATA_W-1:0] fetch_data;
   logic              fetch_done;
   logic              wtb_push;
   logic [ADDR_W-1:0] wtb_addr;
   logic [DATA_W-1:0] wtb_data;
   logic              wtbuf_full;
   logic              wtbuf_empty;
   logic              read_hit;
   logic              read_miss;
   logic              write_hit;
   logic              write_miss;

   cache_memory #(
      .DATA_W  (DATA_W),
      .ADDR_W  (ADDR_W),
      .INDEX_W (INDEX_W)
   ) i_cache_memory (
      .clk         (clk),
      .reset       (reset),
      .valid       (valid),
      .write       (write),
      .addr        (addr),
      .wdata       (wdata),
      .rdata       (rdata),
      .ready       (ready),
      .invalidate  (invalidate),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .fetch_data  (fetch_data),
      .fetch_done  (fetch_done),
      .wtb_push    (wtb_push),
      .wtb_addr    (wtb_addr),
      .wtb_data    (wtb_data),
      .wtbuf_full  (wtbuf_full),
      .wtbuf_empty (wtbuf_empty),
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss)
   );

   write_through_backend #(
      .DATA_W      (DATA_W),
      .ADDR_W      (ADDR_W),
      .WTB_DEPTH_W (WTB_DEPTH_W)
   ) i_write_through_backend (
      .clk         (clk),
      .reset       (reset),
      .wtb_push    (wtb_push),
      .wtb_addr    (wtb_addr),
      .wtb_data    (wtb_data),
      .wtbuf_full  (wtbuf_full),
      .wtbuf_empty (wtbuf_empty),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .fetch_data  (fetch_data),
      .fetch_done  (fetch_done),
      .mem_valid   (mem_valid),
      .mem_write   (mem_write),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_rdata   (mem_rdata),
      .mem_ready   (mem_ready)
   );

   cache_control #(
      .DATA_W       (DATA_W),
      .USE_CTRL_CNT (USE_CTRL_CNT)
   ) i_cache_control (
      .clk         (clk),
      .reset       (reset),
      .ctrl_valid  (ctrl_valid),
      .ctrl_addr   (ctrl_addr),
      .ctrl_rdata  (ctrl_rdata),
      .ctrl_ready  (ctrl_ready),
      .wtbuf_full  (wtbuf_full),
      .wtbuf_empty (wtbuf_empty),
      .read_hit    (read_hit),
      .read_miss   (read_miss),
      .write_hit   (write_hit),
      .write_miss  (write_miss),
      .invalidate  (invalidate)
   );

endmodule

// File: test/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

localparam int LINES = 1 << INDEX_W;
localparam int TAG_W = ADDR_W - INDEX_W;

logic [15:0]       lfsr_state = 16'd23;
logic [DATA_W-1:0] model_mem [1 << ADDR_W];  // Latest value of every word
logic [TAG_W-1:0]  model_tag [LINES];
logic [LINES-1:0]  model_valid;
int unsigned       cnt_read_hit;
int unsigned       cnt_read_miss;
int unsigned       cnt_write_hit;
int unsigned       cnt_write_miss;
int                data_errors;
int                ctrl_errors;
int                protocol_errors;

// Galois form, taps 16 14 13 11
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
   return DATA_W'(32'h9E37_79B9 * (32'(a) + 32'd1));  // Differs for every address
endfunction

// Returns 1 on a hit, allocates the line on a miss
function automatic logic model_read(input logic [ADDR_W-1:0] a);
   logic [INDEX_W-1:0] idx;
   logic               hit;
   idx = a[INDEX_W-1:0];
   hit = model_valid[idx] && (model_tag[idx] == a[ADDR_W-1:INDEX_W]);
   if (hit) begin
      cnt_read_hit++;
   end else begin
      cnt_read_miss++;
      model_valid[idx] = 1'b1;
      model_tag[idx]   = a[ADDR_W-1:INDEX_W];
   end
   return hit;
endfunction

function automatic void model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
   logic [INDEX_W-1:0] idx;
   idx = a[INDEX_W-1:0];
   if (model_valid[idx] && (model_tag[idx] == a[ADDR_W-1:INDEX_W])) cnt_write_hit++;
   else cnt_write_miss++;  // No allocate
   model_mem[a] = d;
endfunction

function automatic void invalidate_model();
   model_valid = '0;
endfunction

function automatic void clear_model_counters();
   cnt_read_hit   = 0;
   cnt_read_miss  = 0;
   cnt_write_hit  = 0;
   cnt_write_miss = 0;
endfunction

function automatic logic [DATA_W-1:0] expected_count(input ctrl_reg_e which);
   int unsigned v;
   case (which)
      CTRL_RW_HIT:     v = cnt_read_hit + cnt_write_hit;
      CTRL_RW_MISS:    v = cnt_read_miss + cnt_write_miss;
      CTRL_READ_HIT:   v = cnt_read_hit;
      CTRL_READ_MISS:  v = cnt_read_miss;
      CTRL_WRITE_HIT:  v = cnt_write_hit;
      CTRL_WRITE_MISS: v = cnt_write_miss;
      default:         v = 0;
   endcase
   return DATA_W'(v);
endfunction

task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
   if (act !== exp) begin
      data_errors++;
      $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
   end
endtask

task automatic check_ctrl(input ctrl_reg_e which, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
   if (act !== exp) begin
      ctrl_errors++;
      $display("FAILED time=%0t signal=ctrl_rdata[%s] expected=%h actual=%h",
               $time, which.name(), exp, act);
   end
endtask

`endif

// File: test/tb_cache.sv
`timescale 1ns/100ps

module tb_cache;

   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int DATA_W      = DATA_W_DEF;
   localparam int ADDR_W      = ADDR_W_DEF;
   localparam int INDEX_W     = INDEX_W_DEF;
   localparam int WTB_DEPTH_W = WTB_DEPTH_W_DEF;
   localparam int CLK_PERIOD  = 40;
   localparam int N_OPS       = 400;
   localparam int MAX_LAT     = 7;  // Three random bits in the responder
   localparam int DEPTH       = 1 << WTB_DEPTH_W;
   localparam int MISS_CYCLES = (DEPTH + 1) * (MAX_LAT + 4) + 4;  // Full drain, then fetch
   localparam int TIMEOUT_NS  = (N_OPS + 200) * MISS_CYCLES * CLK_PERIOD + 10000;

   logic              clk;
   logic              reset;
   logic              valid;
   logic              write;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   logic              ready;
   logic              ctrl_valid;
   ctrl_reg_e         ctrl_addr;
   logic [DATA_W-1:0] ctrl_rdata;
   logic              ctrl_ready;
   logic              mem_valid;
   logic              mem_write;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic [DATA_W-1:0] mem_rdata;
   logic              mem_ready;
   logic              stall_mem;
   logic [DATA_W-1:0] mem_array [1 << ADDR_W];

   `include "tb_cache_model.svh"

   cache_top #(
      .DATA_W       (DATA_W),
      .ADDR_W       (ADDR_W),
      .INDEX_W      (INDEX_W),
      .WTB_DEPTH_W  (WTB_DEPTH_W),
      .USE_CTRL_CNT (1)
   ) i_cache_top (
      .clk        (clk),
      .reset      (reset),
      .valid      (valid),
      .write      (write),
      .addr       (addr),
      .wdata      (wdata),
      .rdata      (rdata),
      .ready      (ready),
      .ctrl_valid (ctrl_valid),
      .ctrl_addr  (ctrl_addr),
      .ctrl_rdata (ctrl_rdata),
      .ctrl_ready (ctrl_ready),
      .mem_valid  (mem_valid),
      .mem_write  (mem_write),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout after %0d ns, the cache stopped answering", TIMEOUT_NS);
      $display("Error counts: data %0d, control %0d, protocol %0d",
               data_errors, ctrl_errors, protocol_errors);
      $display("SIMULATION FAILED");
      $finish;
   end

   // Memory with random latency, held off entirely while stall_mem is set
   initial begin : mem_responder
      int                lat;
      logic [DATA_W-1:0] rd;
      mem_ready = 1'b0;
      mem_rdata = '0;
      forever begin
         @(negedge clk);
         if (mem_valid) begin
            lat = int'(rand_bits(3));
            repeat (lat) @(negedge clk);
            while (stall_mem) @(negedge clk);
            if (mem_write) mem_array[mem_addr] = mem_wdata;
            rd = mem_array[mem_addr];
            @(posedge clk);
            mem_ready <= 1'b1;
            mem_rdata <= rd;
            @(posedge clk);
            mem_ready <= 1'b0;
         end
      end
   end

   task automatic cpu_access(input logic is_write, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] value,
                             output int cycles);
      @(posedge clk);
      valid <= 1'b1;
      write <= is_write;
      addr  <= a;
      wdata <= d;
      @(negedge clk);
      cycles = 0;
      while (!ready && cycles < 2 * MISS_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (!ready) begin
         protocol_errors++;
         $display("No ready within %0d cycles for the access to %h at %0t", cycles, a, $time);
      end
      value = rdata;
      @(posedge clk);
      valid <= 1'b0;
   endtask

   task automatic ctrl_access(input ctrl_reg_e which, output logic [DATA_W-1:0] value);
      int cycles;
      @(posedge clk);
      ctrl_valid <= 1'b1;
      ctrl_addr  <= which;
      @(negedge clk);
      cycles = 0;
      while (!ctrl_ready && cycles < 8) begin
         @(negedge clk);
         cycles++;
      end
      if (!ctrl_ready || cycles != 1) begin
         protocol_errors++;
         $display("ctrl_ready for %s came after %0d cycles instead of one at %0t",
                  which.name(), cycles, $time);
      end
      value = ctrl_rdata;
      @(posedge clk);
      ctrl_valid <= 1'b0;
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] value;
      logic              hit;
      int                cycles;
      hit = model_read(a);
      cpu_access(1'b0, a, '0, value, cycles);
      check_word("rdata", model_mem[a], value);
      if (hit && cycles != 1) begin
         protocol_errors++;
         $display("Read hit at %h took %0d cycles instead of one", a, cycles);
      end
   endtask

   // Buffer known to have room when room_known is set
   task automatic write_random(input logic [ADDR_W-1:0] a, input logic room_known);
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] value;
      int                cycles;
      data = DATA_W'(rand_bits(DATA_W));
      model_write(a, data);
      cpu_access(1'b1, a, data, value, cycles);
      if (room_known && cycles != 1) begin
         protocol_errors++;
         $display("Write to %h with buffer room took %0d cycles instead of one", a, cycles);
      end
   endtask

   task automatic read_counters(input logic expect_zero);
      logic [DATA_W-1:0] value;
      ctrl_reg_e         which;
      for (int r = int'(CTRL_RW_HIT); r <= int'(CTRL_WRITE_MISS); r++) begin
         which = ctrl_reg_e'(r);
         ctrl_access(which, value);
         check_ctrl(which, expect_zero ? '0 : expected_count(which), value);
      end
   endtask

   task automatic send_command(input ctrl_reg_e which);
      logic [DATA_W-1:0] value;
      ctrl_access(which, value);
      check_ctrl(which, '0, value);  // Commands read back zero
      if (which == CTRL_INVALIDATE) invalidate_model();
      if (which == CTRL_RST_CNTRS) clear_model_counters();
   endtask

   task automatic random_ctrl();
      logic [2:0] sel;
      sel = 3'(rand_bits(3));
      if (sel == 3'd0) send_command(CTRL_RST_CNTRS);
      else if (sel == 3'd1) send_command(CTRL_INVALIDATE);
      else read_counters(1'b0);
   endtask

   // Poll until the write buffer reports empty
   task automatic wait_drained();
      logic [DATA_W-1:0] value;
      int                tries;
      tries = 0;
      value = '0;
      while (value != DATA_W'(1) && tries < MISS_CYCLES) begin
         ctrl_access(CTRL_WTB_EMPTY, value);
         tries++;
      end
      check_ctrl(CTRL_WTB_EMPTY, DATA_W'(1), value);
   endtask

   task automatic check_memory();
      for (int i = 0; i < (1 << ADDR_W); i++) begin
         check_word($sformatf("mem_array[%h]", i[ADDR_W-1:0]), model_mem[i], mem_array[i]);
      end
   endtask

   initial begin : stimulus
      logic [DATA_W-1:0] value;
      logic [ADDR_W-1:0] a;
      logic [3:0]        pick;
      reset      = 1'b1;
      valid      = 1'b0;
      write      = 1'b0;
      addr       = '0;
      wdata      = '0;
      ctrl_valid = 1'b0;
      ctrl_addr  = CTRL_RW_HIT;
      stall_mem  = 1'b0;
      for (int i = 0; i < (1 << ADDR_W); i++) begin
         mem_array[i] = fill_word(ADDR_W'(i));
         model_mem[i] = fill_word(ADDR_W'(i));
      end
      invalidate_model();
      clear_model_counters();
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      ctrl_access(CTRL_VERSION, value);
      check_ctrl(CTRL_VERSION, DATA_W'(CACHE_VERSION), value);
      ctrl_access(CTRL_WTB_EMPTY, value);
      check_ctrl(CTRL_WTB_EMPTY, DATA_W'(1), value);
      read_counters(1'b1);

      // Random mix over 64 words so that lines collide
      for (int n = 0; n < N_OPS; n++) begin
         pick = 4'(rand_bits(4));
         a    = ADDR_W'(rand_bits(6));
         if (pick == 4'd0) random_ctrl();
         else if (pick[0]) write_random(a, 1'b0);
         else read_check(a);
      end
      wait_drained();
      check_memory();
      read_counters(1'b0);

      // Every line cached, then invalidated, must miss again
      for (int i = 0; i < LINES; i++) read_check(ADDR_W'(i));
      send_command(CTRL_RST_CNTRS);
      read_counters(1'b1);
      send_command(CTRL_INVALIDATE);
      for (int i = 0; i < LINES; i++) read_check(ADDR_W'(i));
      ctrl_access(CTRL_READ_MISS, value);
      check_ctrl(CTRL_READ_MISS, DATA_W'(LINES), value);
      ctrl_access(CTRL_READ_HIT, value);
      check_ctrl(CTRL_READ_HIT, '0, value);

      // Fill the write buffer while memory holds off
      stall_mem = 1'b1;
      for (int i = 0; i < DEPTH; i++) write_random(ADDR_W'(32 + i), 1'b1);
      ctrl_access(CTRL_WTB_FULL, value);
      check_ctrl(CTRL_WTB_FULL, DATA_W'(1), value);
      ctrl_access(CTRL_WTB_EMPTY, value);
      check_ctrl(CTRL_WTB_EMPTY, '0, value);
      stall_mem = 1'b0;
      wait_drained();
      check_memory();
      read_counters(1'b0);

      $display("Error counts: data %0d, control %0d, protocol %0d",
               data_errors, ctrl_errors, protocol_errors);
      if (data_errors + ctrl_errors + protocol_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+test
design/cache_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_memory.sv
design/write_through_backend.sv
design/cache_control.sv
design/cache_top.sv
test/tb_cache.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_cache \
   -o sim_tb_cache > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "No result line found in sim.log"
   exit 1
fi
exit 0
